/* common/dds_pkg.sv */
package dds_pkg;

   ////////////////////////////////////////
   // sample and phase types
   ////////////////////////////////////////

   typedef logic signed [11:0] sample_t;   // two's complement waveform sample
   typedef logic [31:0]        phase_t;    // accumulator phase and increment
   typedef logic [4:0]         lfsr_t;

   localparam lfsr_t LFSR_SEED = 5'b11111;

   // full scale limits of a sample
   localparam sample_t SAMPLE_MAX = 12'sh7FF;
   localparam sample_t SAMPLE_MIN = 12'sh800;

   ////////////////////////////////////////
   // waveform bundle and selectors
   ////////////////////////////////////////

   typedef struct packed
   {
      sample_t sin;
      sample_t cos;
      sample_t saw;
      sample_t squ;
   } wave_set_t;

   // plain waveform pick for sig_out
   typedef enum logic [1:0]
   {
      wave_sin,
      wave_cos,
      wave_saw,
      wave_squ
   } wave_sel_e;

   // modulation pick for mod_out
   typedef enum logic [1:0]
   {
      mod_ask,
      mod_fsk,
      mod_bpsk,
      mod_lfsr
   } mod_sel_e;

endpackage

/* src/tick_timer.sv */
`timescale 1ns/1ps

module tick_timer #(
   parameter int DIVIDE = 16
) (
   input  logic clk,
   input  logic reset,
   output logic tick
);

   localparam int CW = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;
   localparam logic [CW-1:0] LAST = CW'(DIVIDE - 1);   // final count of a bit period

   logic [CW-1:0] count;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         count <= '0;
      end
      else if (count == LAST)
      begin
         count <= '0;                 // wrap
      end
      else
      begin
         count <= count + 1'b1;
      end
   end

   assign tick = (count == LAST);     // one cycle per period

endmodule

/* src/lfsr_gen.sv */
`timescale 1ns/1ps

module lfsr_gen (
   input  logic clk,
   input  logic reset,
   input  logic advance,
   output logic bit_out
);

   dds_pkg::lfsr_t lfsr_q;
   logic           feedback;

   // taps on bits 0 and 2 give the maximal length of 31
   assign feedback = lfsr_q[0] ^ lfsr_q[2];

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         lfsr_q <= dds_pkg::LFSR_SEED;
      end
      else if (advance)
      begin
         lfsr_q <= {feedback, lfsr_q[4:1]};   // shift right with feedback into bit 4
      end
   end

   // data bit for the modulators
   assign bit_out = lfsr_q[0];

endmodule

/* dds/dds_core.sv */
`timescale 1ns/1ps

module dds_core (
   input  logic               clk,
   input  logic               reset,
   input  dds_pkg::phase_t    phase_inc,
   output dds_pkg::wave_set_t waves
);

   // a quarter period advances the top two phase bits by one
   localparam dds_pkg::phase_t QUARTER = 32'h4000_0000;

   dds_pkg::phase_t    phase_q;
   dds_pkg::wave_set_t wave_d;

   ////////////////////////////////////////
   // parabolic sine approximation
   ////////////////////////////////////////

   function automatic dds_pkg::sample_t sine_of(input dds_pkg::phase_t p);
      logic [10:0] v;
      logic [21:0] prod;
      logic [12:0] mag;
      logic [11:0] mag_c;
      v     = p[30:20];                       // position inside the half period
      prod  = v * (12'd2048 - v);
      mag   = prod[21:9];                     // divide by 512
      mag_c = (mag > 13'd2047) ? 12'd2047 : mag[11:0];   // peak hits 2048
      if (p[31])
      begin
         return dds_pkg::sample_t'(-mag_c);   // second half negative
      end
      return dds_pkg::sample_t'(mag_c);
   endfunction

   ////////////////////////////////////////
   // accumulator
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         phase_q <= '0;
      end
      else
      begin
         phase_q <= phase_q + phase_inc;
      end
   end

   // waveform functions of the current phase
   always_comb
   begin
      wave_d.sin = sine_of(phase_q);
      wave_d.cos = sine_of(phase_q + QUARTER);
      wave_d.saw = dds_pkg::sample_t'(phase_q[31:20] - 12'd2048);   // ramp centred on 0
      wave_d.squ = phase_q[31] ? dds_pkg::SAMPLE_MIN : dds_pkg::SAMPLE_MAX;
   end

   // output stage lags the phase by one cycle
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         waves <= '0;
      end
      else
      begin
         waves <= wave_d;
      end
   end

endmodule

/* src/output_select.sv */
`timescale 1ns/1ps

module output_select (
   input  logic               clk,
   input  logic               reset,
   input  dds_pkg::wave_set_t carrier,
   input  dds_pkg::wave_set_t fsk_wave,
   input  logic               data_bit,
   input  dds_pkg::mod_sel_e  mod_sel,
   input  dds_pkg::wave_sel_e wave_sel,
   output dds_pkg::sample_t   mod_out,
   output dds_pkg::sample_t   sig_out
);

   dds_pkg::sample_t ask_s;
   dds_pkg::sample_t fsk_s;
   dds_pkg::sample_t bpsk_s;
   dds_pkg::sample_t level_s;
   dds_pkg::sample_t inv_cos;
   dds_pkg::sample_t mod_d;
   dds_pkg::sample_t sig_d;

   ////////////////////////////////////////
   // modulators
   ////////////////////////////////////////

   // -(-2048) does not fit so it saturates to +2047
   assign inv_cos = (carrier.cos == dds_pkg::SAMPLE_MIN) ? dds_pkg::SAMPLE_MAX : -carrier.cos;

   assign ask_s   = data_bit ? carrier.cos : '0;       // on/off keying
   assign fsk_s   = fsk_wave.cos;                      // tone from second core
   assign bpsk_s  = data_bit ? carrier.cos : inv_cos;  // 180 degree flip on a zero
   assign level_s = data_bit ? dds_pkg::SAMPLE_MAX : dds_pkg::SAMPLE_MIN;

   always_comb
   begin
      case (mod_sel)
         dds_pkg::mod_ask:  mod_d = ask_s;
         dds_pkg::mod_fsk:  mod_d = fsk_s;
         dds_pkg::mod_bpsk: mod_d = bpsk_s;
         default:           mod_d = level_s;
      endcase
      case (wave_sel)
         dds_pkg::wave_sin: sig_d = carrier.sin;
         dds_pkg::wave_cos: sig_d = carrier.cos;
         dds_pkg::wave_saw: sig_d = carrier.saw;
         default:           sig_d = carrier.squ;
      endcase
   end

   // one cycle of latency on both streams
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         mod_out <= '0;
         sig_out <= '0;
      end
      else
      begin
         mod_out <= mod_d;
         sig_out <= sig_d;
      end
   end

endmodule

/* src/dds_mod_top.sv */
`timescale 1ns/1ps

module dds_mod_top #(
   parameter int              TICK_DIVIDE = 16,
   parameter dds_pkg::phase_t CARRIER_INC = 258
) (
   input  logic               clk,
   input  logic               reset,
   input  dds_pkg::wave_sel_e wave_sel,
   input  dds_pkg::mod_sel_e  mod_sel,
   input  dds_pkg::phase_t    fsk_inc,
   output logic               bit_tick,
   output logic               lfsr_bit,
   output dds_pkg::sample_t   mod_out,
   output dds_pkg::sample_t   sig_out
);

   dds_pkg::wave_set_t carrier_waves;
   dds_pkg::wave_set_t fsk_waves;

   ////////////////////////////////////////
   // bit timing and data
   ////////////////////////////////////////

   tick_timer #(
      .DIVIDE (TICK_DIVIDE)
   ) u_timer (
      .clk   (clk),
      .reset (reset),
      .tick  (bit_tick)
   );

   lfsr_gen u_lfsr (
      .clk     (clk),
      .reset   (reset),
      .advance (bit_tick),      // one shift per bit period
      .bit_out (lfsr_bit)
   );

   ////////////////////////////////////////
   // synthesis and output
   ////////////////////////////////////////

   dds_core u_carrier (
      .clk       (clk),
      .reset     (reset),
      .phase_inc (CARRIER_INC),  // fixed carrier
      .waves     (carrier_waves)
   );

   dds_core u_fsk (
      .clk       (clk),
      .reset     (reset),
      .phase_inc (fsk_inc),
      .waves     (fsk_waves)
   );

   output_select u_out (
      .clk      (clk),
      .reset    (reset),
      .carrier  (carrier_waves),
      .fsk_wave (fsk_waves),
      .data_bit (lfsr_bit),
      .mod_sel  (mod_sel),
      .wave_sel (wave_sel),
      .mod_out  (mod_out),
      .sig_out  (sig_out)
   );

endmodule

/* tests/dds_mod_asserts.sv */
`timescale 1ns/1ps

module dds_mod_asserts (
   input logic              clk,
   input logic              reset,
   input logic              bit_tick,
   input dds_pkg::lfsr_t    lfsr_state,
   input dds_pkg::mod_sel_e mod_sel,
   input dds_pkg::sample_t  mod_out
);

   int unsigned fail_count = 0;   // read by the testbench at the end

   // tick is a single cycle pulse
   a_tick_single: assert property (@(posedge clk) disable iff (reset)
      bit_tick |=> !bit_tick)
   else
   begin
      fail_count++;
      $error("bit_tick stayed high for two cycles");
   end

   a_lfsr_nonzero: assert property (@(posedge clk) disable iff (reset)
      lfsr_state != '0)
   else
   begin
      fail_count++;
      $error("LFSR register reached zero");
   end

   // level mode gives full scale only
   a_level_values: assert property (@(posedge clk) disable iff (reset)
      mod_sel == dds_pkg::mod_lfsr |=>
         (mod_out == dds_pkg::SAMPLE_MAX || mod_out == dds_pkg::SAMPLE_MIN))
   else
   begin
      fail_count++;
      $error("mod_out not full scale in LFSR mode");
   end

endmodule

bind dds_mod_top dds_mod_asserts u_asserts (
   .clk        (clk),
   .reset      (reset),
   .bit_tick   (bit_tick),
   .lfsr_state (u_lfsr.lfsr_q),
   .mod_sel    (mod_sel),
   .mod_out    (mod_out)
);

/* tests/tb_dds_mod.sv */
`timescale 1ns/1ps

module tb_dds_mod;

   localparam int              TICK_DIVIDE = 16;
   localparam dds_pkg::phase_t CARRIER_INC = 258;
   localparam int              NUM_ROWS    = 8;

   // one row of stimulus
   typedef struct packed
   {
      dds_pkg::wave_sel_e wsel;
      dds_pkg::mod_sel_e  msel;
      dds_pkg::phase_t    finc;
      logic [15:0]        cycles;
   } stim_row_t;

   logic               clk = 1'b0;
   logic               reset;
   dds_pkg::wave_sel_e wave_sel;
   dds_pkg::mod_sel_e  mod_sel;
   dds_pkg::phase_t    fsk_inc;
   logic               bit_tick;
   logic               lfsr_bit;
   dds_pkg::sample_t   mod_out;
   dds_pkg::sample_t   sig_out;

   stim_row_t   stim_tab [NUM_ROWS];
   int unsigned cycle_limit = 0;
   int unsigned cycle_count = 0;
   int unsigned error_count = 0;
   int unsigned check_count = 0;

   // reference model state
   int                 m_cnt;
   dds_pkg::lfsr_t     m_lfsr;
   dds_pkg::phase_t    m_phc;
   dds_pkg::phase_t    m_phf;
   dds_pkg::wave_set_t m_wc;
   dds_pkg::wave_set_t m_wf;
   dds_pkg::sample_t   m_mod;
   dds_pkg::sample_t   m_sig;

   dds_mod_top #(
      .TICK_DIVIDE (TICK_DIVIDE),
      .CARRIER_INC (CARRIER_INC)
   ) u_dut (
      .clk      (clk),
      .reset    (reset),
      .wave_sel (wave_sel),
      .mod_sel  (mod_sel),
      .fsk_inc  (fsk_inc),
      .bit_tick (bit_tick),
      .lfsr_bit (lfsr_bit),
      .mod_out  (mod_out),
      .sig_out  (sig_out)
   );

   always #5 clk = ~clk;   // 10 ns period

   ////////////////////////////////////////
   // model functions
   ////////////////////////////////////////

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // parabola over each half period
   function automatic dds_pkg::sample_t parabola_sine(input dds_pkg::phase_t p);
      int v;
      int m;
      v = int'(p[30:20]);
      m = (v * (2048 - v)) / 512;
      if (m > 2047)
         m = 2047;
      if (p[31])
         m = -m;
      return dds_pkg::sample_t'(m);
   endfunction

   function automatic dds_pkg::wave_set_t waves_at(input dds_pkg::phase_t p);
      dds_pkg::wave_set_t w;
      w.sin = parabola_sine(p);
      w.cos = parabola_sine(p + 32'h4000_0000);   // quarter period ahead
      w.saw = dds_pkg::sample_t'(int'(p[31:20]) - 2048);
      w.squ = p[31] ? dds_pkg::sample_t'(-2048) : dds_pkg::sample_t'(2047);
      return w;
   endfunction

   function automatic dds_pkg::sample_t pick_modulated(input dds_pkg::mod_sel_e sel,
                                                       input dds_pkg::wave_set_t c,
                                                       input dds_pkg::wave_set_t f,
                                                       input logic b);
      int n;
      n = -int'(c.cos);
      if (n > 2047)
         n = 2047;   // inversion saturates
      case (sel)
         dds_pkg::mod_ask:  return b ? c.cos : dds_pkg::sample_t'(0);
         dds_pkg::mod_fsk:  return f.cos;
         dds_pkg::mod_bpsk: return b ? c.cos : dds_pkg::sample_t'(n);
         default:           return b ? dds_pkg::sample_t'(2047) : dds_pkg::sample_t'(-2048);
      endcase
   endfunction

   function automatic dds_pkg::sample_t pick_waveform(input dds_pkg::wave_sel_e sel,
                                                      input dds_pkg::wave_set_t c);
      case (sel)
         dds_pkg::wave_sin: return c.sin;
         dds_pkg::wave_cos: return c.cos;
         dds_pkg::wave_saw: return c.saw;
         default:           return c.squ;
      endcase
   endfunction

   ////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////

   task automatic check_sample(input string name, input dds_pkg::sample_t exp,
                               input dds_pkg::sample_t act);
      check_count++;
      if (act !== exp)
      begin
         error_count++;
         $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      check_count++;
      if (act !== exp)
      begin
         error_count++;
         $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      end
   endtask

   task automatic compare_outputs;
      check_bit("bit_tick", m_cnt == TICK_DIVIDE - 1, bit_tick);
      check_bit("lfsr_bit", m_lfsr[0], lfsr_bit);
      check_sample("mod_out", m_mod, mod_out);
      check_sample("sig_out", m_sig, sig_out);
   endtask

   // advance the model over one edge and compare
   task automatic step_cycle;
      logic tick_now;
      @(posedge clk);
      tick_now = (m_cnt == TICK_DIVIDE - 1);
      m_mod    = pick_modulated(mod_sel, m_wc, m_wf, m_lfsr[0]);   // uses waves before update
      m_sig    = pick_waveform(wave_sel, m_wc);
      m_wc     = waves_at(m_phc);
      m_wf     = waves_at(m_phf);
      m_phc    = m_phc + CARRIER_INC;
      m_phf    = m_phf + fsk_inc;
      if (tick_now)
         m_lfsr = {m_lfsr[0] ^ m_lfsr[2], m_lfsr[4:1]};
      m_cnt = tick_now ? 0 : m_cnt + 1;
      #1;
      compare_outputs();
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////

   initial
   begin
      logic [31:0] seed;
      int unsigned total;
      reset    = 1'b1;
      wave_sel = dds_pkg::wave_sin;
      mod_sel  = dds_pkg::mod_ask;
      fsk_inc  = '0;
      seed     = 32'd79;
      stim_tab[0] = '{dds_pkg::wave_sin, dds_pkg::mod_ask,  32'h0100_0000, 16'd100};
      seed = lcg_next(seed);
      stim_tab[1] = '{dds_pkg::wave_cos, dds_pkg::mod_bpsk, seed, 16'd100};
      seed = lcg_next(seed);
      stim_tab[2] = '{dds_pkg::wave_saw, dds_pkg::mod_fsk,  seed, 16'd100};
      seed = lcg_next(seed);
      stim_tab[3] = '{dds_pkg::wave_squ, dds_pkg::mod_fsk,  seed, 16'd100};
      stim_tab[4] = '{dds_pkg::wave_sin, dds_pkg::mod_lfsr, 32'h0080_0000, 16'd100};
      seed = lcg_next(seed);
      stim_tab[5] = '{dds_pkg::wave_cos, dds_pkg::mod_ask,  seed, 16'd100};
      stim_tab[6] = '{dds_pkg::wave_saw, dds_pkg::mod_bpsk, 32'h0200_0000, 16'd100};
      seed = lcg_next(seed);
      stim_tab[7] = '{dds_pkg::wave_squ, dds_pkg::mod_lfsr, seed, 16'd100};
      total = 0;
      foreach (stim_tab[i])
         total += stim_tab[i].cycles;
      cycle_limit = total + 100;

      // model starts in its reset state
      m_cnt  = 0;
      m_lfsr = dds_pkg::LFSR_SEED;
      m_phc  = '0;
      m_phf  = '0;
      m_wc   = '0;
      m_wf   = '0;
      m_mod  = '0;
      m_sig  = '0;

      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      compare_outputs();   // reset values

      for (int i = 0; i < NUM_ROWS; i++)
      begin
         wave_sel = stim_tab[i].wsel;
         mod_sel  = stim_tab[i].msel;
         fsk_inc  = stim_tab[i].finc;
         repeat (stim_tab[i].cycles) step_cycle();
      end

      error_count += u_dut.u_asserts.fail_count;
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   // run limit from the table length
   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_limit != 0 && cycle_count >= cycle_limit)
      begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("checks: %0d, errors: %0d", check_count, error_count);
         $display("test failed");
         $finish;
      end
   end

endmodule

/* tb.f */
common/dds_pkg.sv
src/tick_timer.sv
src/lfsr_gen.sv
dds/dds_core.sv
src/output_select.sv
src/dds_mod_top.sv
tests/dds_mod_asserts.sv
tests/tb_dds_mod.sv

/* Bender.yml */
package:
  name: dds_mod

sources:
  - common/dds_pkg.sv
  - src/tick_timer.sv
  - src/lfsr_gen.sv
  - dds/dds_core.sv
  - src/output_select.sv
  - src/dds_mod_top.sv
  - target: test
    files:
      - tests/dds_mod_asserts.sv
      - tests/tb_dds_mod.sv
